//--- bench/rng_vectors.txt
# Request vectors for rng_top, one line per group of identical requests
# Columns: type code (hex), repeats, words per request, source of the line's last word
#   type 0/1/2 = RDSEED 16/32/64, 4/5/6 = RDRAND 16/32/64
#   source 0 = seed queue, 1 = DRBG, 2 = xorshift stream
# Seed words from fold 1 on, slice position carried across requests
0 1 1 0
1 1 2 0
2 2 4 0
2 2 4 0
# First DRBG block, drained on the fourth request
4 1 1 1
5 1 2 1
6 1 4 1
4 1 1 1
# Long RDRAND run lifts the mode counter past the threshold
6 48 4 2
# RDSEED burst lowers the counter again
1 10 2 0
# Stream buffer drains, then DRBG blocks resume
6 2 4 2
5 2 2 1
4 4 1 1
# Counter back at the threshold, stream refill
4 1 1 2
# Mixed tail
2 1 4 0
0 2 1 0
5 1 2 2

//--- rng_top.f
logic/rng_pkg.sv
logic/entropy_conditioner.sv
logic/counter_drbg.sv
logic/xorshift_stream.sv
logic/output_buffer.sv
logic/rng_top.sv
bench/rng_top_assertions.sv
bench/rng_top_tb.sv

//--- Bender.yml
package:
  name: rng_top

sources:
  - logic/rng_pkg.sv
  - logic/entropy_conditioner.sv
  - logic/counter_drbg.sv
  - logic/xorshift_stream.sv
  - logic/output_buffer.sv
  - logic/rng_top.sv
  - target: test
    files:
      - bench/rng_top_assertions.sv
      - bench/rng_top_tb.sv

//--- bench/rng_top_tb.sv
/*
 * Testbench for the random number unit
 * Replays request vectors and checks each host word against a reference model
 */
`timescale 1ns/100ps

module rng_top_tb;
    import rng_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      rand_req;
    rand_req_e rand_req_type;
    host_out_t host;

    // Vector lines as read from the file
    rand_req_e line_type[$];
    int        line_reps[$];
    int        line_words[$];
    int        line_src[$];
    bit        vectors_loaded;

    // Reference model state
    logic [31:0] noise;
    seed_t       seed_cur;
    int          seed_pos;
    block_t      drbg_key;
    block_t      drbg_ctr;
    stream_t     xs_state;
    block_t      rnd_buf;
    int          rnd_pos;
    int          rnd_src;
    int          mode_cnt;

    bit req_open;
    int error_count;
    int req_passed;
    int req_failed;

    rng_top rng_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .rand_req_i      (rand_req),
        .rand_req_type_i (rand_req_type),
        .host_o          (host)
    );

    bind output_buffer rng_top_assertions rng_top_assertions_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .seed_valid_i (seed_valid_i),
        .seed_i       (seed_i),
        .seed_ready_o (seed_ready_o),
        .wr_ptr_q     (wr_ptr_q),
        .rd_ptr_q     (rd_ptr_q),
        .host_o       (host_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input out_word_t got, input out_word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_type(input string name, input rand_req_e got, input rand_req_e exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %s (%0h), expected %s", $time, name, got.name(),
                     got, exp.name());
            error_count++;
        end
    endtask

    // Request kind rebuilt from the source flag and word count the buffer latched
    function automatic rand_req_e served_kind(input logic rnd, input logic [2:0] total);
        logic [1:0] size_code;
        case (total)
            3'd1:    size_code = 2'd0;
            3'd2:    size_code = 2'd1;
            3'd4:    size_code = 2'd2;
            default: size_code = 2'd3;
        endcase
        return rand_req_e'({rnd, size_code});
    endfunction

    // Galois LFSR with taps 32 22 2 1, first 256 bits form A, next 256 form B
    task automatic next_fold();
        seed_t word_a;
        seed_t word_b;
        for (int i = 0; i < 2 * SEED_W; i++) begin
            if (i < SEED_W)
                word_a[i] = noise[0];
            else
                word_b[i - SEED_W] = noise[0];
            noise = (noise >> 1) ^ (noise[0] ? 32'h8020_0003 : 32'h0);
        end
        seed_cur = word_a ^ word_b;
        seed_pos = 0;
    endtask

    task automatic xs_next(output stream_t word);
        stream_t x;
        x = xs_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        xs_state = x;
        word = x;
    endtask

    // Source follows the mode counter at the moment the buffer empties
    task automatic refill_buffer();
        stream_t lo;
        stream_t hi;
        if (mode_cnt >= STREAM_MODE_THRESHOLD) begin
            xs_next(lo);
            xs_next(hi);
            rnd_buf = {hi, lo};
            rnd_src = 2;
        end else begin
            rnd_buf  = drbg_key ^ drbg_ctr;
            drbg_ctr = drbg_ctr + 1'b1;
            rnd_src  = 1;
        end
        rnd_pos = 0;
    endtask

    // Fold 0 keys both generators, fold 1 is the first queued seed
    task automatic model_init();
        noise = LFSR_SEED;
        next_fold();
        drbg_key = seed_cur[SEED_W-1:BLOCK_W];
        drbg_ctr = seed_cur[BLOCK_W-1:0];
        xs_state = (seed_cur[STREAM_W-1:0] == '0) ? XS_FALLBACK : seed_cur[STREAM_W-1:0];
        mode_cnt = 0;
        refill_buffer();
        next_fold();
    endtask

    task automatic expected_word(input bit rnd, output out_word_t word, output int src);
        if (rnd) begin
            word = rnd_buf[OUT_W*rnd_pos +: OUT_W];
            src  = rnd_src;
            rnd_pos++;
            if (rnd_pos == BLOCK_WORDS)
                refill_buffer();
        end else begin
            word = seed_cur[OUT_W*seed_pos +: OUT_W];
            src  = 0;
            seed_pos++;
            if (seed_pos == SEED_WORDS)
                next_fold();
        end
    endtask

    task automatic load_vectors();
        int        fd;
        int        code;
        int        reps;
        int        words;
        int        src;
        string     text;
        rand_req_e kind;
        fd = $fopen("bench/rng_vectors.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the vectors file bench/rng_vectors.txt");
            error_count++;
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (text.substr(0, 0) != "#" &&
                    $sscanf(text, "%h %d %d %d", code, reps, words, src) == 4) begin
                    if ($cast(kind, code)) begin
                        line_type.push_back(kind);
                        line_reps.push_back(reps);
                        line_words.push_back(words);
                        line_src.push_back(src);
                    end else begin
                        $display("Error: unknown request code %0h in the vectors file", code);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            vectors_loaded = 1'b1;
        end
    endtask

    task automatic run_request(input rand_req_e kind, input int nwords, output int src);
        out_word_t exp;
        time       prev_t;
        int        got;
        int        errors_before;
        errors_before = error_count;
        if (kind[2])
            mode_cnt = (mode_cnt < 2**MODE_CNT_W - 1) ? mode_cnt + 1 : mode_cnt;
        else
            mode_cnt = (mode_cnt > 0) ? mode_cnt - 1 : 0;
        got    = 0;
        prev_t = 0;
        @(posedge clk);
        #1;
        req_open      = 1'b1;
        rand_req_type = kind;
        rand_req      = 1'b1;
        while (got < nwords) begin
            @(negedge clk);
            if (host.valid === 1'b1) begin
                expected_word(kind[2], exp, src);
                check_word("host_o.word", host.word, exp);
                if (got == 0) begin
                    // Words still owed are already counted down by the first one
                    check_type("output_buffer_inst request",
                               served_kind(rng_top_inst.output_buffer_inst.req_rnd_q,
                                           rng_top_inst.output_buffer_inst.words_left_q + 3'd1),
                               kind);
                end else if (($time - prev_t) % (PACE_DIV * 10) != 0) begin
                    $display("Error at %0t ns: words %0d ns apart, not a multiple of the pace",
                             $time, $time - prev_t);
                    error_count++;
                end
                prev_t = $time;
                got++;
                // Host drops the request once the first word is seen
                if (got == 1) begin
                    @(posedge clk);
                    #1 rand_req = 1'b0;
                end
            end
        end
        @(posedge clk);
        req_open = 1'b0;
        // Quiet window so a surplus word shows up as unrequested
        repeat (2 * PACE_DIV) @(posedge clk);
        if (error_count == errors_before)
            req_passed++;
        else
            req_failed++;
        $display("Request %0d %s: %0d words, %s", req_passed + req_failed, kind.name(), nwords,
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    always @(negedge clk) begin
        if (!req_open && host.valid !== 1'b0) begin
            $display("Error at %0t ns: host word valid while no request is outstanding", $time);
            error_count++;
        end
    end

    initial begin
        wait (vectors_loaded);
        repeat (20 + 6000 * line_type.size()) @(posedge clk);
        $display("Timeout: the DUT stopped delivering words before the last request was served");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int src;
        rst_n          = 1'b0;
        rand_req       = 1'b0;
        rand_req_type  = RDSEED_16;
        req_open       = 1'b0;
        error_count    = 0;
        req_passed     = 0;
        req_failed     = 0;
        vectors_loaded = 1'b0;
        load_vectors();
        model_init();
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (line_type[i]) begin
            for (int r = 0; r < line_reps[i]; r++)
                run_request(line_type[i], line_words[i], src);
            if (src != line_src[i]) begin
                $display("Error at %0t ns: vector line %0d ends on source %0d, file gives %0d",
                         $time, i, src, line_src[i]);
                error_count++;
            end
        end
        $display("Requests %0d, passed %0d, failed %0d, errors %0d",
                 req_passed + req_failed, req_passed, req_failed, error_count);
        if (error_count == 0 && req_failed == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- bench/rng_top_assertions.sv
/*
 * Output buffer checks on the seed handshake, queue fill and host word pacing
 */
`timescale 1ns/100ps

module rng_top_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     seed_valid_i,
    input rng_pkg::seed_t           seed_i,
    input logic                     seed_ready_o,
    input logic [rng_pkg::QPTR_W:0] wr_ptr_q,
    input logic [rng_pkg::QPTR_W:0] rd_ptr_q,
    input rng_pkg::host_out_t       host_o
);
    import rng_pkg::*;

    logic [QPTR_W:0] fill_level;

    assign fill_level = wr_ptr_q - rd_ptr_q;

    // A waiting seed stays put until the queue takes it
    seed_hold: assert property (@(posedge clk) disable iff (!rst_n)
        seed_valid_i && !seed_ready_o |=> seed_valid_i && $stable(seed_i))
        else $error("seed_valid dropped or seed changed before the transfer");

    ready_only_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !seed_ready_o |-> fill_level == SEED_QUEUE_DEPTH)
        else $error("seed_ready low while the seed queue is not full");

    host_pacing: assert property (@(posedge clk) disable iff (!rst_n)
        host_o.valid |=> !host_o.valid [*PACE_DIV-1])
        else $error("two host words within one pace period");

endmodule

//--- logic/rng_top.sv
/*
 * Random number unit top level
 * Conditioner, DRBG, xorshift stream and output buffer
 */
`timescale 1ns/100ps

module rng_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rand_req_i,
    input  rng_pkg::rand_req_e rand_req_type_i,
    output rng_pkg::host_out_t host_o
);
    import rng_pkg::*;

    key_bus_t key_bus;
    logic     seed_valid;
    seed_t    seed;
    logic     seed_ready;
    logic     blk_valid;
    block_t   blk;
    logic     blk_ready;
    logic     str_valid;
    stream_t  str;
    logic     str_ready;

    entropy_conditioner entropy_conditioner_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_o        (key_bus),
        .seed_valid_o (seed_valid),
        .seed_o       (seed),
        .seed_ready_i (seed_ready)
    );

    counter_drbg counter_drbg_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_i       (key_bus),
        .blk_valid_o (blk_valid),
        .blk_o       (blk),
        .blk_ready_i (blk_ready)
    );

    xorshift_stream xorshift_stream_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_i       (key_bus),
        .str_valid_o (str_valid),
        .str_o       (str),
        .str_ready_i (str_ready)
    );

    output_buffer output_buffer_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .seed_valid_i    (seed_valid),
        .seed_i          (seed),
        .seed_ready_o    (seed_ready),
        .blk_valid_i     (blk_valid),
        .blk_i           (blk),
        .blk_ready_o     (blk_ready),
        .str_valid_i     (str_valid),
        .str_i           (str),
        .str_ready_o     (str_ready),
        .rand_req_i      (rand_req_i),
        .rand_req_type_i (rand_req_type_i),
        .host_o          (host_o)
    );

endmodule

//--- logic/output_buffer.sv
/*
 * Output buffer
 * Seed queue for RDSEED, refilled RDRAND buffer, paced 16-bit host words
 */
`timescale 1ns/100ps

module output_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               seed_valid_i,
    input  rng_pkg::seed_t     seed_i,
    output logic               seed_ready_o,
    input  logic               blk_valid_i,
    input  rng_pkg::block_t    blk_i,
    output logic               blk_ready_o,
    input  logic               str_valid_i,
    input  rng_pkg::stream_t   str_i,
    output logic               str_ready_o,
    input  logic               rand_req_i,
    input  rng_pkg::rand_req_e rand_req_type_i,
    output rng_pkg::host_out_t host_o
);
    import rng_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SERVE,
        WAIT_SRC
    } req_state_e;

    // Seed queue with wrap bit on each pointer
    seed_t             seed_mem [SEED_QUEUE_DEPTH];
    logic [QPTR_W:0]   wr_ptr_q;
    logic [QPTR_W:0]   rd_ptr_q;
    logic              full;
    logic              empty;
    logic              push;

    block_t            buf_q;
    logic              buf_valid_q;
    logic              half_q;
    logic              src_stream;
    logic              buf_drain;

    logic [MODE_CNT_W-1:0]          mode_cnt_q;
    logic [$clog2(PACE_DIV)-1:0]    pace_cnt_q;
    logic                           tick;
    logic [$clog2(SEED_WORDS)-1:0]  seed_idx_q;
    logic [$clog2(BLOCK_WORDS)-1:0] buf_idx_q;

    req_state_e        state_q;
    logic [2:0]        words_left_q;
    logic [2:0]        req_words;
    logic              req_rnd_q;
    logic              hold_q;
    logic              accept;
    logic              src_ok;
    logic              deliver;
    logic              host_vld_q;
    out_word_t         host_word_q;

    assign full  = (wr_ptr_q[QPTR_W] != rd_ptr_q[QPTR_W]) &&
                   (wr_ptr_q[QPTR_W-1:0] == rd_ptr_q[QPTR_W-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign push  = seed_valid_i && seed_ready_o;
    assign seed_ready_o = !full;

    // A stream refill half done keeps the stream selected
    assign src_stream  = half_q || (mode_cnt_q >= STREAM_MODE_THRESHOLD);
    assign blk_ready_o = !buf_valid_q && !src_stream;
    assign str_ready_o = !buf_valid_q && src_stream;

    assign tick = (pace_cnt_q == PACE_DIV - 1);

    always_comb begin
        case (rand_req_type_i)
            RDSEED_32, RDRAND_32: req_words = 3'd2;
            RDSEED_64, RDRAND_64: req_words = 3'd4;
            default:              req_words = 3'd1;
        endcase
    end

    assign accept = tick && (state_q == IDLE) && rand_req_i && !hold_q &&
                    (rand_req_type_i[2] ? buf_valid_q : !empty);
    assign src_ok    = req_rnd_q ? buf_valid_q : !empty;
    assign deliver   = tick && (state_q != IDLE) && src_ok;
    assign buf_drain = deliver && req_rnd_q && (buf_idx_q == BLOCK_WORDS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pace_cnt_q <= '0;
        end else if (tick) begin
            pace_cnt_q <= '0;
        end else begin
            pace_cnt_q <= pace_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
        end else if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    // RDRAND buffer fill state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
            half_q      <= 1'b0;
        end else if (blk_valid_i && blk_ready_o) begin
            buf_valid_q <= 1'b1;
        end else if (str_valid_i && str_ready_o) begin
            half_q <= !half_q;
            if (half_q) begin
                buf_valid_q <= 1'b1;
            end
        end else if (buf_drain) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            seed_mem[wr_ptr_q[QPTR_W-1:0]] <= seed_i;
        end
        if (blk_valid_i && blk_ready_o) begin
            buf_q <= blk_i;
        end else if (str_valid_i && str_ready_o) begin
            buf_q[STREAM_W*half_q +: STREAM_W] <= str_i;
        end
        if (deliver) begin
            host_word_q <= req_rnd_q ? buf_q[OUT_W*buf_idx_q +: OUT_W]
                                     : seed_mem[rd_ptr_q[QPTR_W-1:0]][OUT_W*seed_idx_q +: OUT_W];
        end
    end

    // Request FSM, all steps land on pace ticks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            words_left_q <= '0;
            req_rnd_q    <= 1'b0;
            hold_q       <= 1'b0;
            mode_cnt_q   <= '0;
            seed_idx_q   <= '0;
            buf_idx_q    <= '0;
            rd_ptr_q     <= '0;
            host_vld_q   <= 1'b0;
        end else begin
            host_vld_q <= 1'b0;
            if (!rand_req_i) begin
                hold_q <= 1'b0;
            end
            if (accept) begin
                state_q      <= SERVE;
                words_left_q <= req_words;
                req_rnd_q    <= rand_req_type_i[2];
                if (rand_req_type_i[2]) begin
                    if (mode_cnt_q != '1) begin
                        mode_cnt_q <= mode_cnt_q + 1'b1;
                    end
                end else if (mode_cnt_q != '0) begin
                    mode_cnt_q <= mode_cnt_q - 1'b1;
                end
            end else if (deliver) begin
                host_vld_q   <= 1'b1;
                words_left_q <= words_left_q - 1'b1;
                if (words_left_q == 3'd1) begin
                    state_q <= IDLE;
                    // Host still holding the finished request
                    hold_q  <= rand_req_i;
                end else begin
                    state_q <= SERVE;
                end
                if (req_rnd_q) begin
                    buf_idx_q <= buf_idx_q + 1'b1;
                end else if (seed_idx_q == SEED_WORDS - 1) begin
                    seed_idx_q <= '0;
                    rd_ptr_q   <= rd_ptr_q + 1'b1;
                end else begin
                    seed_idx_q <= seed_idx_q + 1'b1;
                end
            end else if (tick && (state_q == SERVE)) begin
                state_q <= WAIT_SRC;
            end
        end
    end

    assign host_o = '{valid: host_vld_q, word: host_word_q};

endmodule

//--- logic/xorshift_stream.sv
/*
 * Xorshift stream generator
 * 64-bit state keyed once, one step per transfer
 */
`timescale 1ns/100ps

module xorshift_stream (
    input  logic              clk,
    input  logic              rst_n,
    input  rng_pkg::key_bus_t key_i,
    output logic              str_valid_o,
    output rng_pkg::stream_t  str_o,
    input  logic              str_ready_i
);
    import rng_pkg::*;

    stream_t state_q;
    stream_t key_word;
    stream_t x1;
    stream_t x2;
    logic    keyed_q;

    assign key_word = key_i.seed[STREAM_W-1:0];

    // Shifts 13 left, 7 right, 17 left
    always_comb begin
        x1    = state_q ^ (state_q << 13);
        x2    = x1 ^ (x1 >> 7);
        str_o = x2 ^ (x2 << 17);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keyed_q <= 1'b0;
        end else if (key_i.valid) begin
            keyed_q <= 1'b1;
        end
    end

    // An all-zero state would lock up
    always_ff @(posedge clk) begin
        if (key_i.valid) begin
            state_q <= (key_word == '0) ? XS_FALLBACK : key_word;
        end else if (str_valid_o && str_ready_i) begin
            state_q <= str_o;
        end
    end

    assign str_valid_o = keyed_q;

endmodule

//--- logic/counter_drbg.sv
/*
 * Counter-mode DRBG
 * Delivers key XOR counter blocks, counter advances per transfer
 */
`timescale 1ns/100ps

module counter_drbg (
    input  logic              clk,
    input  logic              rst_n,
    input  rng_pkg::key_bus_t key_i,
    output logic              blk_valid_o,
    output rng_pkg::block_t   blk_o,
    input  logic              blk_ready_i
);
    import rng_pkg::*;

    block_t key_q;
    block_t ctr_q;
    logic   keyed_q;
    logic   xfer;

    assign xfer = blk_valid_o && blk_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keyed_q <= 1'b0;
        end else if (key_i.valid) begin
            keyed_q <= 1'b1;
        end
    end

    // Upper seed half keys, lower half starts the counter
    always_ff @(posedge clk) begin
        if (key_i.valid) begin
            key_q <= key_i.seed[SEED_W-1:BLOCK_W];
            ctr_q <= key_i.seed[BLOCK_W-1:0];
        end else if (xfer) begin
            ctr_q <= ctr_q + 1'b1;
        end
    end

    assign blk_valid_o = keyed_q;
    assign blk_o       = key_q ^ ctr_q;

endmodule

//--- logic/entropy_conditioner.sv
/*
 * Entropy conditioner
 * LFSR noise stand-in folded 512 bits into each 256-bit seed
 */
`timescale 1ns/100ps

module entropy_conditioner (
    input  logic              clk,
    input  logic              rst_n,
    output rng_pkg::key_bus_t key_o,
    output logic              seed_valid_o,
    output rng_pkg::seed_t    seed_o,
    input  logic              seed_ready_i
);
    import rng_pkg::*;

    logic [31:0]                  lfsr_q;
    logic [$clog2(FOLD_BITS)-1:0] bit_cnt_q;
    logic [$clog2(SEED_W)-1:0]    idx;
    seed_t                        fold_q;
    logic                         raw_bit;
    logic                         second_half;
    logic                         step;
    logic                         fold_done;
    logic                         keyed_q;
    logic                         key_vld_q;
    logic                         seed_pend_q;

    assign raw_bit     = lfsr_q[0];
    assign idx         = bit_cnt_q[$clog2(SEED_W)-1:0];
    assign second_half = (bit_cnt_q >= SEED_W);

    // Back-pressure freezes the LFSR while a finished seed waits
    assign step      = !seed_pend_q || seed_ready_i;
    assign fold_done = step && (bit_cnt_q == FOLD_BITS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q      <= LFSR_SEED;
            bit_cnt_q   <= '0;
            keyed_q     <= 1'b0;
            key_vld_q   <= 1'b0;
            seed_pend_q <= 1'b0;
        end else begin
            key_vld_q <= 1'b0;
            if (seed_pend_q && seed_ready_i) begin
                seed_pend_q <= 1'b0;
            end
            if (step) begin
                lfsr_q    <= {1'b0, lfsr_q[31:1]} ^ (raw_bit ? LFSR_TAPS : '0);
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (fold_done) begin
                if (!keyed_q) begin
                    keyed_q   <= 1'b1;
                    key_vld_q <= 1'b1;
                end else begin
                    seed_pend_q <= 1'b1;
                end
            end
        end
    end

    // First half loads word A, second half XORs word B on top
    always_ff @(posedge clk) begin
        if (step) begin
            fold_q[idx] <= raw_bit ^ (second_half & fold_q[idx]);
        end
    end

    assign key_o        = '{valid: key_vld_q, seed: fold_q};
    assign seed_valid_o = seed_pend_q;
    assign seed_o       = fold_q;

endmodule

//--- logic/rng_pkg.sv
/*
 * Random number unit shared definitions
 * Request encoding, data widths, tuning constants and bus structs
 */
package rng_pkg;

    // Bit 2 of the request code selects RDRAND
    typedef enum logic [2:0] {
        RDSEED_16 = 3'b000,
        RDSEED_32 = 3'b001,
        RDSEED_64 = 3'b010,
        RDRAND_16 = 3'b100,
        RDRAND_32 = 3'b101,
        RDRAND_64 = 3'b110
    } rand_req_e;

    localparam int SEED_W   = 256;
    localparam int BLOCK_W  = 128;
    localparam int STREAM_W = 64;
    localparam int OUT_W    = 16;

    typedef logic [SEED_W-1:0]   seed_t;
    typedef logic [BLOCK_W-1:0]  block_t;
    typedef logic [STREAM_W-1:0] stream_t;
    typedef logic [OUT_W-1:0]    out_word_t;

    localparam int SEED_QUEUE_DEPTH = 8;
    localparam int QPTR_W           = $clog2(SEED_QUEUE_DEPTH);
    localparam int SEED_WORDS       = SEED_W / OUT_W;
    localparam int BLOCK_WORDS      = BLOCK_W / OUT_W;

    // Conditioner input per seed
    localparam int FOLD_BITS = 512;

    // Host word pacing
    localparam int PACE_DIV = 5;

    // Generator mode switch
    localparam int STREAM_MODE_THRESHOLD = 45;
    localparam int MODE_CNT_W            = 6;

    // Noise stand-in, Galois taps 32 22 2 1
    localparam logic [31:0] LFSR_SEED = 32'hACE1_2468;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    localparam stream_t XS_FALLBACK = 64'h9E37_79B9_7F4A_7C15;

    // One-cycle key broadcast to both generators
    typedef struct packed {
        logic  valid;
        seed_t seed;
    } key_bus_t;

    typedef struct packed {
        logic      valid;
        out_word_t word;
    } host_out_t;

endpackage
